//--- Makefile
VERILATOR  = verilator
TOP        = udp_rx_noc_out_tb
RTL_TOP    = udp_rx_noc_out
FILELIST   = vlog.f
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- source/data_masker.sv
module data_masker #(
     parameter int width_p = 128
)(
     input  logic [width_p-1:0]                 unmasked_data
    ,input  logic [udp_rx_pkg::PADBYTES_W-1:0]  padbytes
    ,input  logic                               last
    ,output logic [width_p-1:0]                 masked_data
);

    localparam int NUM_BYTES = width_p / 8;

    // First payload byte sits at the top, so the pad bytes are the lowest ones.
    always_comb begin
        masked_data = unmasked_data;
        if (last) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (i < int'(padbytes)) begin
                    masked_data[i*8 +: 8] = 8'h00;
                end
            end
        end
    end

endmodule

//--- source/udp_port_table.sv
module udp_port_table #(
     parameter int TABLE_ENTRIES = 8
)(
     input  logic                               clk
    ,input  logic                               rst

    ,input  logic                               cfg_wr
    ,input  logic [$clog2(TABLE_ENTRIES)-1:0]   cfg_index
    ,input  logic [udp_rx_pkg::PORT_W-1:0]      cfg_port
    ,input  logic [udp_rx_pkg::XY_W-1:0]        cfg_x
    ,input  logic [udp_rx_pkg::XY_W-1:0]        cfg_y
    ,input  logic [udp_rx_pkg::FBITS_W-1:0]     cfg_fbits

    ,input  logic [udp_rx_pkg::PORT_W-1:0]      lookup_port
    ,output logic                               hit
    ,output logic [udp_rx_pkg::XY_W-1:0]        x
    ,output logic [udp_rx_pkg::XY_W-1:0]        y
    ,output logic [udp_rx_pkg::FBITS_W-1:0]     fbits
);
    import udp_rx_pkg::*;

    logic [TABLE_ENTRIES-1:0]   entry_valid;
    logic [PORT_W-1:0]          entry_port  [TABLE_ENTRIES];
    logic [XY_W-1:0]            entry_x     [TABLE_ENTRIES];
    logic [XY_W-1:0]            entry_y     [TABLE_ENTRIES];
    logic [FBITS_W-1:0]         entry_fbits [TABLE_ENTRIES];
    logic [TABLE_ENTRIES-1:0]   match;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (cfg_wr) begin
            entry_valid[cfg_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            entry_port[cfg_index]  <= cfg_port;
            entry_x[cfg_index]     <= cfg_x;
            entry_y[cfg_index]     <= cfg_y;
            entry_fbits[cfg_index] <= cfg_fbits;
        end
    end

    // A one-hot match lets the fields of all entries be OR-ed.
    always_comb begin
        x     = '0;
        y     = '0;
        fbits = '0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            match[i] = entry_valid[i] && (entry_port[i] == lookup_port);
            if (match[i]) begin
                x     = x | entry_x[i];
                y     = y | entry_y[i];
                fbits = fbits | entry_fbits[i];
            end
        end
    end

    assign hit = |match;

    a_single_match: assert property (@(posedge clk) disable iff (rst) $onehot0(match))
        else $error("port table has more than one entry for port %h", lookup_port);

endmodule

//--- source/udp_rx_noc_out.sv
module udp_rx_noc_out #(
     parameter int SRC_X         = 0
    ,parameter int SRC_Y         = 0
    ,parameter int TABLE_ENTRIES = 8
)(
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  logic                                   hdr_val
    ,input  logic [udp_rx_pkg::IP_ADDR_W-1:0]       src_ip
    ,input  logic [udp_rx_pkg::IP_ADDR_W-1:0]       dst_ip
    ,input  logic [udp_rx_pkg::PORT_W-1:0]          src_port
    ,input  logic [udp_rx_pkg::PORT_W-1:0]          dst_port
    ,input  logic [udp_rx_pkg::UDP_LEN_W-1:0]       udp_length
    ,input  logic [udp_rx_pkg::PKT_ID_W-1:0]        packet_id
    ,input  logic [udp_rx_pkg::TS_W-1:0]            timestamp

    ,input  logic                                   data_val
    ,input  logic [udp_rx_pkg::NOC_DATA_W-1:0]      data
    ,input  logic                                   last
    ,input  logic [udp_rx_pkg::PADBYTES_W-1:0]      padbytes

    ,input  logic                                   cfg_wr
    ,input  logic [$clog2(TABLE_ENTRIES)-1:0]       cfg_index
    ,input  logic [udp_rx_pkg::PORT_W-1:0]          cfg_port
    ,input  logic [udp_rx_pkg::XY_W-1:0]            cfg_x
    ,input  logic [udp_rx_pkg::XY_W-1:0]            cfg_y
    ,input  logic [udp_rx_pkg::FBITS_W-1:0]         cfg_fbits

    ,output logic                                   noc_val
    ,output logic [udp_rx_pkg::NOC_DATA_W-1:0]      noc_data
    ,output logic                                   idle
);
    import udp_rx_pkg::*;

    logic               store_inputs;
    flit_sel            flit_sel_w;
    logic               last_output;
    logic               no_data;
    logic               lookup_hit;
    logic [PORT_W-1:0]  lookup_port;
    logic               table_hit;
    logic [XY_W-1:0]    table_x;
    logic [XY_W-1:0]    table_y;
    logic [FBITS_W-1:0] table_fbits;

    udp_rx_noc_out_ctrl ctrl (
         .clk(clk), .rst(rst)
        ,.hdr_val(hdr_val), .data_val(data_val)
        ,.last_output(last_output), .no_data(no_data), .lookup_hit(lookup_hit)
        ,.store_inputs(store_inputs), .flit_sel(flit_sel_w)
        ,.noc_val(noc_val), .idle(idle)
    );

    udp_rx_noc_out_datap #(.SRC_X(SRC_X), .SRC_Y(SRC_Y)) datap (
         .clk(clk), .rst(rst)
        ,.src_ip(src_ip), .dst_ip(dst_ip), .src_port(src_port), .dst_port(dst_port)
        ,.udp_length(udp_length), .packet_id(packet_id), .timestamp(timestamp)
        ,.data(data), .last(last), .padbytes(padbytes)
        ,.store_inputs(store_inputs), .flit_sel(flit_sel_w)
        ,.noc_data(noc_data), .last_output(last_output), .no_data(no_data)
        ,.lookup_port(lookup_port), .table_hit(table_hit), .table_x(table_x)
        ,.table_y(table_y), .table_fbits(table_fbits), .lookup_hit(lookup_hit)
    );

    udp_port_table #(.TABLE_ENTRIES(TABLE_ENTRIES)) port_table (
         .clk(clk), .rst(rst)
        ,.cfg_wr(cfg_wr), .cfg_index(cfg_index), .cfg_port(cfg_port)
        ,.cfg_x(cfg_x), .cfg_y(cfg_y), .cfg_fbits(cfg_fbits)
        ,.lookup_port(lookup_port), .hit(table_hit)
        ,.x(table_x), .y(table_y), .fbits(table_fbits)
    );

endmodule

//--- source/udp_rx_noc_out_ctrl.sv
module udp_rx_noc_out_ctrl (
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic                   hdr_val
    ,input  logic                   data_val

    ,input  logic                   last_output
    ,input  logic                   no_data
    ,input  logic                   lookup_hit

    ,output logic                   store_inputs
    ,output udp_rx_pkg::flit_sel    flit_sel
    ,output logic                   noc_val
    ,output logic                   idle
);
    import udp_rx_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        HDR,
        META,
        DATA,
        DROP
    } state_t;

    state_t state_reg;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        state_next   = state_reg;
        store_inputs = 1'b0;
        case (state_reg)
            IDLE: begin
                if (hdr_val) begin
                    store_inputs = 1'b1;
                    if (lookup_hit) begin
                        state_next = HDR;
                    end else if (!no_data) begin
                        state_next = DROP;
                    end
                end
            end
            HDR:  state_next = META;
            META: state_next = no_data ? IDLE : DATA;
            DATA, DROP: begin
                if (data_val && last_output) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_comb begin
        case (state_reg)
            HDR:     flit_sel = SEL_HDR_FLIT;
            META:    flit_sel = SEL_META_FLIT;
            default: flit_sel = SEL_DATA_FLIT;
        endcase
    end

    assign noc_val = (state_reg == HDR) || (state_reg == META)
                     || ((state_reg == DATA) && data_val);
    assign idle    = (state_reg == IDLE);

    // Together these catch a missing or early last and beats on an empty datagram.
    a_hdr_when_idle: assert property (@(posedge clk) disable iff (rst) hdr_val |-> idle)
        else $error("hdr_val while a datagram is in flight");
    a_beat_gap: assert property (@(posedge clk) disable iff (rst)
        hdr_val |=> !data_val ##1 !data_val)
        else $error("payload beat within two cycles of hdr_val");
    a_beat_in_body: assert property (@(posedge clk) disable iff (rst)
        data_val |-> (state_reg == DATA) || (state_reg == DROP))
        else $error("payload beat outside a datagram body");

endmodule

//--- source/udp_rx_noc_out_datap.sv
module udp_rx_noc_out_datap #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
)(
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  logic [udp_rx_pkg::IP_ADDR_W-1:0]       src_ip
    ,input  logic [udp_rx_pkg::IP_ADDR_W-1:0]       dst_ip
    ,input  logic [udp_rx_pkg::PORT_W-1:0]          src_port
    ,input  logic [udp_rx_pkg::PORT_W-1:0]          dst_port
    ,input  logic [udp_rx_pkg::UDP_LEN_W-1:0]       udp_length
    ,input  logic [udp_rx_pkg::PKT_ID_W-1:0]        packet_id
    ,input  logic [udp_rx_pkg::TS_W-1:0]            timestamp
    ,input  logic [udp_rx_pkg::NOC_DATA_W-1:0]      data
    ,input  logic                                   last
    ,input  logic [udp_rx_pkg::PADBYTES_W-1:0]      padbytes

    ,input  logic                                   store_inputs
    ,input  udp_rx_pkg::flit_sel                    flit_sel

    ,output logic [udp_rx_pkg::NOC_DATA_W-1:0]      noc_data
    ,output logic                                   last_output
    ,output logic                                   no_data

    ,output logic [udp_rx_pkg::PORT_W-1:0]          lookup_port
    ,input  logic                                   table_hit
    ,input  logic [udp_rx_pkg::XY_W-1:0]            table_x
    ,input  logic [udp_rx_pkg::XY_W-1:0]            table_y
    ,input  logic [udp_rx_pkg::FBITS_W-1:0]         table_fbits
    ,output logic                                   lookup_hit
);
    import udp_rx_pkg::*;

    logic [IP_ADDR_W-1:0]   src_ip_reg;
    logic [IP_ADDR_W-1:0]   dst_ip_reg;
    logic [PORT_W-1:0]      src_port_reg;
    logic [PORT_W-1:0]      dst_port_reg;
    logic [UDP_LEN_W-1:0]   udp_length_reg;
    logic [PKT_ID_W-1:0]    packet_id_reg;
    logic [TS_W-1:0]        timestamp_reg;
    logic [XY_W-1:0]        dst_x_reg;
    logic [XY_W-1:0]        dst_y_reg;
    logic [FBITS_W-1:0]     dst_fbits_reg;

    logic [PORT_W-1:0]      dst_port_next;
    logic [UDP_LEN_W-1:0]   udp_length_next;
    logic [UDP_LEN_W-1:0]   data_size;
    logic [UDP_LEN_W-1:0]   full_flits;
    logic [MSG_LEN_W-1:0]   num_data_flits;
    logic [NOC_DATA_W-1:0]  masked_data;
    hdr_flit_t              hdr_flit;
    meta_flit_t             meta_flit;

    // Length register drives the flit count.
    always_ff @(posedge clk) begin
        if (rst) begin
            udp_length_reg <= '0;
        end else begin
            udp_length_reg <= udp_length_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_inputs) begin
            src_ip_reg    <= src_ip;
            dst_ip_reg    <= dst_ip;
            src_port_reg  <= src_port;
            dst_port_reg  <= dst_port;
            packet_id_reg <= packet_id;
            timestamp_reg <= timestamp;
            dst_x_reg     <= table_x;
            dst_y_reg     <= table_y;
            dst_fbits_reg <= table_fbits;
        end
    end

    // Lookup runs on the incoming port while storing.
    assign dst_port_next   = store_inputs ? dst_port : dst_port_reg;
    assign udp_length_next = store_inputs ? udp_length : udp_length_reg;
    assign lookup_port     = dst_port_next;
    assign lookup_hit      = table_hit;

    assign data_size      = udp_length_next - UDP_LEN_W'(UDP_HDR_BYTES);
    assign full_flits     = data_size >> NOC_DATA_BYTES_W;
    assign num_data_flits = MSG_LEN_W'(full_flits)
                            + MSG_LEN_W'(data_size[NOC_DATA_BYTES_W-1:0] != '0);

    assign no_data     = (data_size == '0);
    assign last_output = last;

    data_masker #(
        .width_p        (NOC_DATA_W)
    ) masker (
         .unmasked_data (data)
        ,.padbytes      (padbytes)
        ,.last          (last)
        ,.masked_data   (masked_data)
    );

    always_comb begin
        hdr_flit                = '0;
        hdr_flit.dst_x          = dst_x_reg;
        hdr_flit.dst_y          = dst_y_reg;
        hdr_flit.dst_fbits      = dst_fbits_reg;
        // One metadata flit ahead of the data.
        hdr_flit.msg_len        = MSG_LEN_W'(1) + num_data_flits;
        hdr_flit.src_x          = XY_W'(SRC_X);
        hdr_flit.src_y          = XY_W'(SRC_Y);
        hdr_flit.src_fbits      = PKT_IF_FBITS;
        hdr_flit.msg_type       = UDP_RX_SEGMENT;
        hdr_flit.packet_id      = packet_id_reg;
        hdr_flit.timestamp      = timestamp_reg;
        hdr_flit.metadata_flits = 4'd1;
    end

    always_comb begin
        meta_flit             = '0;
        meta_flit.src_ip      = src_ip_reg;
        meta_flit.dst_ip      = dst_ip_reg;
        meta_flit.src_port    = src_port_reg;
        meta_flit.dst_port    = dst_port_reg;
        meta_flit.data_length = data_size;
    end

    always_comb begin
        case (flit_sel)
            SEL_HDR_FLIT:  noc_data = hdr_flit;
            SEL_META_FLIT: noc_data = meta_flit;
            default:       noc_data = masked_data;
        endcase
    end

    a_pad_on_last: assert property (@(posedge clk) disable iff (rst) !last |-> padbytes == '0)
        else $error("padbytes %0d on a beat that is not the last", padbytes);

endmodule

//--- source/udp_rx_pkg.sv
package udp_rx_pkg;

    // Flit and beat geometry.
    localparam int NOC_DATA_W       = 128;
    localparam int NOC_DATA_BYTES_W = 4;
    localparam int PADBYTES_W       = 4;

    // Network header fields.
    localparam int IP_ADDR_W     = 32;
    localparam int PORT_W        = 16;
    localparam int UDP_LEN_W     = 16;
    localparam int UDP_HDR_BYTES = 8;

    // Mesh addressing.
    localparam int XY_W      = 4;
    localparam int FBITS_W   = 4;
    localparam int MSG_LEN_W = 8;

    // Tracker stats.
    localparam int PKT_ID_W = 16;
    localparam int TS_W     = 32;

    // Endpoint select of the packet interface on this tile.
    localparam logic [FBITS_W-1:0] PKT_IF_FBITS = 4'd1;

    typedef enum logic [7:0] {
        NOC_MSG_NONE   = 8'd0,
        TCP_RX_SEGMENT = 8'd12,
        UDP_RX_SEGMENT = 8'd14,
        UDP_TX_SEGMENT = 8'd15
    } noc_msg_type;

    typedef enum logic [1:0] {
        SEL_HDR_FLIT  = 2'd0,
        SEL_META_FLIT = 2'd1,
        SEL_DATA_FLIT = 2'd2
    } flit_sel;

    localparam int HDR_USED_W  = 4 * XY_W + 2 * FBITS_W + MSG_LEN_W + 8
                                 + PKT_ID_W + TS_W + 4;
    localparam int META_USED_W = 2 * IP_ADDR_W + 2 * PORT_W + UDP_LEN_W;

    typedef struct packed {
        logic [XY_W-1:0]                dst_x;
        logic [XY_W-1:0]                dst_y;
        logic [FBITS_W-1:0]             dst_fbits;
        logic [MSG_LEN_W-1:0]           msg_len;
        logic [XY_W-1:0]                src_x;
        logic [XY_W-1:0]                src_y;
        logic [FBITS_W-1:0]             src_fbits;
        noc_msg_type                    msg_type;
        logic [PKT_ID_W-1:0]            packet_id;
        logic [TS_W-1:0]                timestamp;
        logic [3:0]                     metadata_flits;
        logic [NOC_DATA_W-HDR_USED_W-1:0] fill;
    } hdr_flit_t;

    typedef struct packed {
        logic [IP_ADDR_W-1:0]              src_ip;
        logic [IP_ADDR_W-1:0]              dst_ip;
        logic [PORT_W-1:0]                 src_port;
        logic [PORT_W-1:0]                 dst_port;
        logic [UDP_LEN_W-1:0]              data_length;
        logic [NOC_DATA_W-META_USED_W-1:0] fill;
    } meta_flit_t;

endpackage

//--- verif/udp_rx_noc_out_tb.sv
module udp_rx_noc_out_tb;
    import udp_rx_pkg::*;

    localparam int SRC_X         = 2;
    localparam int SRC_Y         = 3;
    localparam int TABLE_ENTRIES = 8;
    localparam int IDX_W         = $clog2(TABLE_ENTRIES);
    localparam int NUM_DATAGRAMS = 200;
    localparam int IDLE_TIMEOUT  = 100;

    logic                   clk;
    logic                   rst;
    logic                   hdr_val;
    logic [IP_ADDR_W-1:0]   src_ip;
    logic [IP_ADDR_W-1:0]   dst_ip;
    logic [PORT_W-1:0]      src_port;
    logic [PORT_W-1:0]      dst_port;
    logic [UDP_LEN_W-1:0]   udp_length;
    logic [PKT_ID_W-1:0]    packet_id;
    logic [TS_W-1:0]        timestamp;
    logic                   data_val;
    logic [NOC_DATA_W-1:0]  data;
    logic                   last;
    logic [PADBYTES_W-1:0]  padbytes;
    logic                   cfg_wr;
    logic [IDX_W-1:0]       cfg_index;
    logic [PORT_W-1:0]      cfg_port;
    logic [XY_W-1:0]        cfg_x;
    logic [XY_W-1:0]        cfg_y;
    logic [FBITS_W-1:0]     cfg_fbits;
    logic                   noc_val;
    logic [NOC_DATA_W-1:0]  noc_data;
    logic                   idle;

    // Reference copy of the port table.
    logic                   tbl_valid [TABLE_ENTRIES];
    logic [PORT_W-1:0]      tbl_port  [TABLE_ENTRIES];
    logic [XY_W-1:0]        tbl_x     [TABLE_ENTRIES];
    logic [XY_W-1:0]        tbl_y     [TABLE_ENTRIES];
    logic [FBITS_W-1:0]     tbl_fbits [TABLE_ENTRIES];

    logic [NOC_DATA_W-1:0]  exp_q [$];
    logic [NOC_DATA_W-1:0]  exp_flit;
    int                     hits;
    int                     misses;

    udp_rx_noc_out #(
         .SRC_X         (SRC_X)
        ,.SRC_Y         (SRC_Y)
        ,.TABLE_ENTRIES (TABLE_ENTRIES)
    ) i_dut (
         .clk(clk), .rst(rst)
        ,.hdr_val(hdr_val), .src_ip(src_ip), .dst_ip(dst_ip)
        ,.src_port(src_port), .dst_port(dst_port), .udp_length(udp_length)
        ,.packet_id(packet_id), .timestamp(timestamp)
        ,.data_val(data_val), .data(data), .last(last), .padbytes(padbytes)
        ,.cfg_wr(cfg_wr), .cfg_index(cfg_index), .cfg_port(cfg_port)
        ,.cfg_x(cfg_x), .cfg_y(cfg_y), .cfg_fbits(cfg_fbits)
        ,.noc_val(noc_val), .noc_data(noc_data), .idle(idle)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic bit port_in_table(input logic [PORT_W-1:0] port);
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            if (tbl_valid[i] && tbl_port[i] == port) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic write_entry(input int idx, input logic [PORT_W-1:0] port);
        logic [XY_W-1:0]    x;
        logic [XY_W-1:0]    y;
        logic [FBITS_W-1:0] fb;
        x  = XY_W'($urandom);
        y  = XY_W'($urandom);
        fb = FBITS_W'($urandom);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_index <= IDX_W'(idx);
        cfg_port  <= port;
        cfg_x     <= x;
        cfg_y     <= y;
        cfg_fbits <= fb;
        @(posedge clk);
        cfg_wr <= 1'b0;
        tbl_valid[idx] = 1'b1;
        tbl_port[idx]  = port;
        tbl_x[idx]     = x;
        tbl_y[idx]     = y;
        tbl_fbits[idx] = fb;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!idle) begin
            cycles++;
            assert (cycles <= IDLE_TIMEOUT) else begin
                $display("TEST FAILED");
                $fatal(1, "timed out waiting for idle to rise");
            end
            @(negedge clk);
        end
    endtask

    task automatic send_datagram(input logic [PORT_W-1:0] dport);
        logic [IP_ADDR_W-1:0]      sip;
        logic [IP_ADDR_W-1:0]      dip;
        logic [PORT_W-1:0]         sport;
        logic [PKT_ID_W-1:0]       pid;
        logic [TS_W-1:0]           ts;
        int                        payload;
        int                        nbeats;
        int                        pad;
        int                        hit_idx;
        hdr_flit_t                 h;
        meta_flit_t                m;
        logic [NOC_DATA_W-1:0]     beats [8];
        logic [NOC_DATA_W-1:0]     mask;
        sip     = $urandom;
        dip     = $urandom;
        sport   = PORT_W'($urandom);
        pid     = PKT_ID_W'($urandom);
        ts      = $urandom;
        payload = $urandom % 101;
        nbeats  = (payload + 15) / 16;
        pad     = nbeats * 16 - payload;
        hit_idx = -1;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            if (tbl_valid[i] && tbl_port[i] == dport) begin
                hit_idx = i;
            end
        end
        for (int b = 0; b < nbeats; b++) begin
            beats[b] = {$urandom, $urandom, $urandom, $urandom};
        end
        if (hit_idx >= 0) begin
            hits++;
            h                = '0;
            h.dst_x          = tbl_x[hit_idx];
            h.dst_y          = tbl_y[hit_idx];
            h.dst_fbits      = tbl_fbits[hit_idx];
            h.msg_len        = MSG_LEN_W'(nbeats + 1);
            h.src_x          = XY_W'(SRC_X);
            h.src_y          = XY_W'(SRC_Y);
            h.src_fbits      = PKT_IF_FBITS;
            h.msg_type       = UDP_RX_SEGMENT;
            h.packet_id      = pid;
            h.timestamp      = ts;
            h.metadata_flits = 4'd1;
            exp_q.push_back(h);
            m             = '0;
            m.src_ip      = sip;
            m.dst_ip      = dip;
            m.src_port    = sport;
            m.dst_port    = dport;
            m.data_length = UDP_LEN_W'(payload);
            exp_q.push_back(m);
            for (int b = 0; b < nbeats; b++) begin
                mask = (b == nbeats - 1) ? ({NOC_DATA_W{1'b1}} << (8 * pad)) : '1;
                exp_q.push_back(beats[b] & mask);
            end
        end else begin
            misses++;
        end
        @(posedge clk);
        hdr_val    <= 1'b1;
        src_ip     <= sip;
        dst_ip     <= dip;
        src_port   <= sport;
        dst_port   <= dport;
        udp_length <= UDP_LEN_W'(payload + UDP_HDR_BYTES);
        packet_id  <= pid;
        timestamp  <= ts;
        @(posedge clk);
        hdr_val <= 1'b0;
        // Two quiet cycles before the first beat.
        @(posedge clk);
        for (int b = 0; b < nbeats; b++) begin
            repeat ($urandom % 3) begin
                @(posedge clk);
                data_val <= 1'b0;
            end
            @(posedge clk);
            data_val <= 1'b1;
            data     <= beats[b];
            last     <= (b == nbeats - 1);
            padbytes <= (b == nbeats - 1) ? PADBYTES_W'(pad) : '0;
        end
        if (nbeats > 0) begin
            @(posedge clk);
            data_val <= 1'b0;
            last     <= 1'b0;
            padbytes <= '0;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && noc_val) begin
            assert (exp_q.size() != 0) else begin
                $display("TEST FAILED");
                $fatal(1, "flit output at time %0t while none was expected", $time);
            end
            exp_flit = exp_q.pop_front();
            assert (noc_data == exp_flit) else begin
                $display("error: time %0t noc_data expected %h got %h",
                         $time, exp_flit, noc_data);
                $display("TEST FAILED");
                $fatal(1, "flit mismatch");
            end
        end
    end

    initial begin
        int                idx;
        logic [PORT_W-1:0] port;
        rst        = 1'b1;
        hdr_val    = 1'b0;
        src_ip     = '0;
        dst_ip     = '0;
        src_port   = '0;
        dst_port   = '0;
        udp_length = UDP_LEN_W'(UDP_HDR_BYTES);
        packet_id  = '0;
        timestamp  = '0;
        data_val   = 1'b0;
        data       = '0;
        last       = 1'b0;
        padbytes   = '0;
        cfg_wr     = 1'b0;
        cfg_index  = '0;
        cfg_port   = '0;
        cfg_x      = '0;
        cfg_y      = '0;
        cfg_fbits  = '0;
        hits       = 0;
        misses     = 0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            tbl_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        void'($urandom(10));
        @(negedge clk);
        assert (!noc_val) else begin
            $display("error: time %0t noc_val expected 0 got %b", $time, noc_val);
            $display("TEST FAILED");
            $fatal(1, "noc_val high after reset");
        end
        assert (idle) else begin
            $display("error: time %0t idle expected 1 got %b", $time, idle);
            $display("TEST FAILED");
            $fatal(1, "idle low after reset");
        end
        // Six entries with distinct ports.
        for (int i = 0; i < 6; i++) begin
            do begin
                port = PORT_W'($urandom);
            end while (port_in_table(port));
            write_entry(i, port);
        end
        for (int n = 0; n < NUM_DATAGRAMS; n++) begin
            if (n % 40 == 39) begin
                // Move an existing port to new coordinates.
                idx = $urandom % 6;
                write_entry(idx, tbl_port[idx]);
                port = tbl_port[idx];
            end else if ($urandom % 3 != 0) begin
                port = tbl_port[$urandom % 6];
            end else begin
                port = PORT_W'($urandom);
            end
            send_datagram(port);
            wait_idle();
            assert (exp_q.size() == 0) else begin
                $display("TEST FAILED");
                $fatal(1, "datagram %0d ended with %0d flits never output", n, exp_q.size());
            end
            repeat ($urandom % 4) @(posedge clk);
        end
        wait_idle();
        repeat (4) @(negedge clk);
        if (exp_q.size() == 0 && hits > 0 && misses > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "%0d flits left over, %0d hits, %0d misses", exp_q.size(), hits, misses);
        end
    end

endmodule

//--- vlog.f
source/udp_rx_pkg.sv
source/udp_port_table.sv
source/data_masker.sv
source/udp_rx_noc_out_datap.sv
source/udp_rx_noc_out_ctrl.sv
source/udp_rx_noc_out.sv
verif/udp_rx_noc_out_tb.sv
